// File: rtl/adcfifo_pkg.sv
`default_nettype none

package adcfifo_pkg;

  localparam int ADC_W    = 10;          // adc sample width
  localparam int ERR_W    = 3;           // ovf, slow ufl, fast ufl
  localparam int THRESH_W = 17;          // segment threshold width

  localparam logic [THRESH_W-1:0] THRESH_RESET = 17'd65536;

  // host register map
  typedef enum logic [7:0] {
    FIFO_STAT                = 8'h10,    // empty + error flags, write bit0 clears
    FIFO_STATE               = 8'h11,
    FIFO_FIRST_ERROR         = 8'h12,
    FIFO_FIRST_ERROR_STATE   = 8'h13,
    DEBUG_FIFO_READS         = 8'h14,    // 4 bytes
    DEBUG_FIFO_READS_FREEZE  = 8'h15,    // 4 bytes
    STREAM_SEGMENT_THRESHOLD = 8'h16,    // 3 bytes
    ADC_LOW_RES              = 8'h17,    // bit0 low_res, bit1 lsb select
    FIFO_UNDERFLOW_COUNT     = 8'h18,
    FIFO_NO_UNDERFLOW_ERROR  = 8'h19,
    CAPTURE_DONE             = 8'h1a,
    FAST_FIFO_READ_MODE      = 8'h1b,
    ADCREAD_ADDR             = 8'h20,    // fifo head, pops on read
    CAPTURE_ARM              = 8'h21
  } reg_addr_t;

  typedef enum logic [2:0] {
    CAP_IDLE      = 3'd0,
    CAP_ARMED     = 3'd1,
    CAP_CAPTURING = 3'd2,
    CAP_DONE      = 3'd3
  } cap_state_t;

endpackage

`default_nettype wire

// File: rtl/reg_adcfifo.sv
`default_nettype none

module reg_adcfifo #(
  parameter int BYTECNT_W = 7
) (
  input  wire                                  clk_usb,
  input  wire                                  reset,
  input  wire  [7:0]                           reg_address,
  input  wire  [BYTECNT_W-1:0]                 reg_bytecnt,
  input  wire  [7:0]                           reg_datai,
  output logic [7:0]                           reg_datao,
  input  wire                                  reg_read,
  input  wire                                  reg_write,
  input  wire  [7:0]                           fifo_dout,
  input  wire                                  fifo_empty,
  input  wire  adcfifo_pkg::cap_state_t        cap_state,
  input  wire                                  capture_done,
  input  wire  [adcfifo_pkg::ERR_W-1:0]        fifo_error_stat,
  input  wire  [adcfifo_pkg::ERR_W-1:0]        fifo_first_error_stat,
  input  wire  adcfifo_pkg::cap_state_t        fifo_first_error_state,
  input  wire  [7:0]                           underflow_count,
  input  wire  [31:0]                          fifo_read_count,
  input  wire  [31:0]                          fifo_read_count_error_freeze,
  output logic                                 fifo_rd_en,
  output logic                                 low_res,
  output logic                                 low_res_lsb,
  output logic                                 fast_fifo_read_mode,
  output logic [adcfifo_pkg::THRESH_W-1:0]     stream_segment_threshold,
  output logic                                 clear_fifo_errors,
  output logic                                 no_underflow_errors,
  output logic                                 arm
);

  logic [1:0]  byte_sel;
  logic [31:0] thresh_ext;
  logic        reg_read_r;                   // previous reg_read for edge detect
  logic        rd_en_slow;                   // registered pop, slow mode
  logic        rd_edge;

  assign byte_sel   = reg_bytecnt[1:0];      // widest register is 4 bytes
  assign thresh_ext = 32'(stream_segment_threshold);
  assign rd_edge    = reg_read && !reg_read_r &&
                      (reg_address == adcfifo_pkg::ADCREAD_ADDR);

  // fast mode pops in the first read cycle, slow one cycle later
  assign fifo_rd_en = fast_fifo_read_mode ? rd_edge : rd_en_slow;

  always_comb begin
    reg_datao = 8'h00;                       // idle bus reads zero
    if (reg_read) begin
      case (reg_address)
        adcfifo_pkg::FIFO_STAT:
          reg_datao = {fifo_empty, {(7 - adcfifo_pkg::ERR_W){1'b0}}, fifo_error_stat};
        adcfifo_pkg::FIFO_STATE:               reg_datao = {5'b0, cap_state};
        adcfifo_pkg::FIFO_FIRST_ERROR:
          reg_datao = {{(8 - adcfifo_pkg::ERR_W){1'b0}}, fifo_first_error_stat};
        adcfifo_pkg::FIFO_FIRST_ERROR_STATE:   reg_datao = {5'b0, fifo_first_error_state};
        adcfifo_pkg::DEBUG_FIFO_READS:
          reg_datao = fifo_read_count[{byte_sel, 3'b000} +: 8];
        adcfifo_pkg::DEBUG_FIFO_READS_FREEZE:
          reg_datao = fifo_read_count_error_freeze[{byte_sel, 3'b000} +: 8];
        adcfifo_pkg::STREAM_SEGMENT_THRESHOLD:
          reg_datao = thresh_ext[{byte_sel, 3'b000} +: 8];
        adcfifo_pkg::ADC_LOW_RES:              reg_datao = {6'b0, low_res_lsb, low_res};
        adcfifo_pkg::FIFO_UNDERFLOW_COUNT:     reg_datao = underflow_count;
        adcfifo_pkg::FIFO_NO_UNDERFLOW_ERROR:  reg_datao = {7'b0, no_underflow_errors};
        adcfifo_pkg::CAPTURE_DONE:             reg_datao = {7'b0, capture_done};
        adcfifo_pkg::FAST_FIFO_READ_MODE:      reg_datao = {7'b0, fast_fifo_read_mode};
        adcfifo_pkg::ADCREAD_ADDR:             reg_datao = fifo_dout;  // fwft head
        default:                               reg_datao = 8'h00;
      endcase
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      low_res                  <= 1'b0;
      low_res_lsb              <= 1'b0;
      clear_fifo_errors        <= 1'b0;
      no_underflow_errors      <= 1'b0;
      stream_segment_threshold <= adcfifo_pkg::THRESH_RESET;
      arm                      <= 1'b0;
    end else begin
      arm <= 1'b0;                           // single cycle pulse
      if (reg_write) begin
        case (reg_address)
          adcfifo_pkg::ADC_LOW_RES: begin
            low_res     <= reg_datai[0];
            low_res_lsb <= reg_datai[1];
          end
          adcfifo_pkg::STREAM_SEGMENT_THRESHOLD: begin
            case (byte_sel)
              2'd0:    stream_segment_threshold[7:0]  <= reg_datai;
              2'd1:    stream_segment_threshold[15:8] <= reg_datai;
              2'd2:    stream_segment_threshold[16]   <= reg_datai[0];
              default: ;                     // no fourth byte
            endcase
          end
          adcfifo_pkg::FIFO_STAT:               clear_fifo_errors   <= reg_datai[0];
          adcfifo_pkg::FIFO_NO_UNDERFLOW_ERROR: no_underflow_errors <= reg_datai[0];
          adcfifo_pkg::CAPTURE_ARM:             arm                 <= reg_datai[0];
          default: ;
        endcase
      end
    end
  end

  // fast mode drops out on a write to any other register
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      fast_fifo_read_mode <= 1'b0;
    end else if (reg_write) begin
      fast_fifo_read_mode <= (reg_address == adcfifo_pkg::FAST_FIFO_READ_MODE) &&
                             reg_datai[0];
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      reg_read_r <= 1'b0;
      rd_en_slow <= 1'b0;
    end else begin
      reg_read_r <= reg_read;
      rd_en_slow <= rd_edge;                 // pop after host sampled head
    end
  end

  a_rd_en_single: assert property (@(posedge clk_usb) disable iff (reset)
    fifo_rd_en |=> !fifo_rd_en);

endmodule

`default_nettype wire

// File: rtl/adc_capture_ctrl.sv
`default_nettype none

module adc_capture_ctrl (
  input  wire                                  clk_usb,
  input  wire                                  reset,
  input  wire                                  arm,
  input  wire                                  trigger,
  input  wire  [adcfifo_pkg::ADC_W-1:0]        adc_data,
  input  wire                                  adc_valid,
  input  wire                                  low_res,
  input  wire                                  low_res_lsb,
  input  wire  [adcfifo_pkg::THRESH_W-1:0]     stream_segment_threshold,
  output logic                                 fifo_wr_en,
  output logic [7:0]                           fifo_din,
  output logic                                 fifo_flush,
  output adcfifo_pkg::cap_state_t              cap_state,
  output logic                                 capture_done
);

  logic [adcfifo_pkg::THRESH_W-1:0] sample_cnt;    // samples taken this segment
  logic [7:0]                       lo_byte;       // held low byte, full res
  logic                             lo_pend;       // low byte still to write
  logic                             last;          // threshold reached

  assign capture_done = (cap_state == adcfifo_pkg::CAP_DONE);

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      cap_state  <= adcfifo_pkg::CAP_IDLE;
      fifo_wr_en <= 1'b0;
      fifo_flush <= 1'b0;
      sample_cnt <= '0;
      lo_pend    <= 1'b0;
      last       <= 1'b0;
    end else begin
      fifo_wr_en <= 1'b0;
      fifo_flush <= 1'b0;
      if (arm) begin                         // arm restarts from any state
        cap_state  <= adcfifo_pkg::CAP_ARMED;
        fifo_flush <= 1'b1;
        sample_cnt <= '0;
        lo_pend    <= 1'b0;
        last       <= 1'b0;
      end else begin
        case (cap_state)
          adcfifo_pkg::CAP_ARMED:
            if (trigger) cap_state <= adcfifo_pkg::CAP_CAPTURING;
          adcfifo_pkg::CAP_CAPTURING: begin
            if (lo_pend) begin               // second byte of full res sample
              fifo_wr_en <= 1'b1;
              fifo_din   <= lo_byte;
              lo_pend    <= 1'b0;
            end else if (last) begin
              cap_state <= adcfifo_pkg::CAP_DONE;  // cycle after last write
            end else if (adc_valid) begin
              fifo_wr_en <= 1'b1;
              sample_cnt <= sample_cnt + 1'b1;
              last       <= (sample_cnt + 1'b1 >= stream_segment_threshold);
              if (low_res) begin
                fifo_din <= low_res_lsb ? adc_data[7:0] : adc_data[9:2];
              end else begin
                fifo_din <= {6'b0, adc_data[9:8]};  // msbs first
                lo_byte  <= adc_data[7:0];
                lo_pend  <= 1'b1;
              end
            end
          end
          default: ;                         // idle, done wait for arm
        endcase
      end
    end
  end

  // full res needs a free cycle for the second byte
  a_valid_gap: assert property (@(posedge clk_usb) disable iff (reset)
    (cap_state == adcfifo_pkg::CAP_CAPTURING && !low_res && adc_valid) |=> !adc_valid);

  a_wr_window: assert property (@(posedge clk_usb) disable iff (reset)
    fifo_wr_en |-> (cap_state == adcfifo_pkg::CAP_CAPTURING ||
                    $past(cap_state) == adcfifo_pkg::CAP_CAPTURING));

endmodule

`default_nettype wire

// File: rtl/adc_sample_fifo.sv
`default_nettype none

module adc_sample_fifo #(
  parameter int FIFO_DEPTH = 64
) (
  input  wire        clk_usb,
  input  wire        reset,
  input  wire        fifo_flush,
  input  wire        fifo_wr_en,
  input  wire  [7:0] fifo_din,
  input  wire        fifo_rd_en,
  output logic [7:0] fifo_dout,
  output logic       fifo_empty,
  output logic       overflow_evt,
  output logic       underflow_evt
);

  localparam int AW = $clog2(FIFO_DEPTH);

  logic [7:0]  mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;                      // occupancy, 0..FIFO_DEPTH
  logic          full;
  logic          do_wr;
  logic          do_rd;

  assign full       = (count == FIFO_DEPTH);
  assign fifo_empty = (count == '0);
  assign do_wr      = fifo_wr_en && !full;   // writes to full are dropped
  assign do_rd      = fifo_rd_en && !fifo_empty;
  assign fifo_dout  = mem[rd_ptr];           // fall through head

  always_ff @(posedge clk_usb) begin
    if (do_wr) mem[wr_ptr] <= fifo_din;
  end

  always_ff @(posedge clk_usb) begin
    if (reset || fifo_flush) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      overflow_evt  <= 1'b0;
      underflow_evt <= 1'b0;
    end else begin
      overflow_evt  <= fifo_wr_en && full;
      underflow_evt <= fifo_rd_en && fifo_empty;
      if (do_wr) wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                           // both or neither, no change
      endcase
    end
  end

  a_no_overfill: assert property (@(posedge clk_usb) disable iff (reset)
    count <= FIFO_DEPTH);

endmodule

`default_nettype wire

// File: rtl/fifo_error_tracker.sv
`default_nettype none

module fifo_error_tracker (
  input  wire                                  clk_usb,
  input  wire                                  reset,
  input  wire                                  overflow_evt,
  input  wire                                  underflow_evt,
  input  wire                                  fifo_rd_en,
  input  wire                                  fast_fifo_read_mode,
  input  wire                                  no_underflow_errors,
  input  wire                                  clear_fifo_errors,
  input  wire  adcfifo_pkg::cap_state_t        cap_state,
  output logic [adcfifo_pkg::ERR_W-1:0]        fifo_error_stat,
  output logic [adcfifo_pkg::ERR_W-1:0]        fifo_first_error_stat,
  output adcfifo_pkg::cap_state_t              fifo_first_error_state,
  output logic [7:0]                           underflow_count,
  output logic [31:0]                          fifo_read_count,
  output logic [31:0]                          fifo_read_count_error_freeze
);

  logic [adcfifo_pkg::ERR_W-1:0] err_evt;

  assign err_evt[0] = overflow_evt;
  assign err_evt[1] = underflow_evt && !fast_fifo_read_mode && !no_underflow_errors;
  assign err_evt[2] = underflow_evt && fast_fifo_read_mode;  // always flagged

  always_ff @(posedge clk_usb) begin
    if (reset || clear_fifo_errors) begin
      fifo_error_stat        <= '0;
      fifo_first_error_stat  <= '0;
      fifo_first_error_state <= adcfifo_pkg::CAP_IDLE;
      underflow_count        <= 8'd0;
    end else begin
      fifo_error_stat <= fifo_error_stat | err_evt;  // sticky
      if (fifo_first_error_stat == '0 && err_evt != '0) begin
        fifo_first_error_stat  <= err_evt;
        fifo_first_error_state <= cap_state;
      end
      if (underflow_evt && underflow_count != 8'hff)
        underflow_count <= underflow_count + 1'b1;   // saturates
    end
  end

  // read count runs through error clears
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      fifo_read_count              <= '0;
      fifo_read_count_error_freeze <= '0;
    end else begin
      if (fifo_rd_en) fifo_read_count <= fifo_read_count + 1'b1;
      if (!clear_fifo_errors && fifo_first_error_stat == '0 && err_evt != '0)
        fifo_read_count_error_freeze <= fifo_read_count;  // snapshot at first error
    end
  end

endmodule

`default_nettype wire

// File: rtl/adc_fifo_top.sv
`default_nettype none

module adc_fifo_top #(
  parameter int FIFO_DEPTH = 64,
  parameter int BYTECNT_W  = 7
) (
  input  wire                               clk_usb,
  input  wire                               reset,
  input  wire  [7:0]                        reg_address,
  input  wire  [BYTECNT_W-1:0]              reg_bytecnt,
  input  wire  [7:0]                        reg_datai,
  output wire  [7:0]                        reg_datao,
  input  wire                               reg_read,
  input  wire                               reg_write,
  input  wire  [adcfifo_pkg::ADC_W-1:0]     adc_data,
  input  wire                               adc_valid,
  input  wire                               trigger
);

  wire                                fifo_rd_en;
  wire                                fifo_wr_en;
  wire                                fifo_flush;
  wire [7:0]                          fifo_din;
  wire [7:0]                          fifo_dout;
  wire                                fifo_empty;
  wire                                overflow_evt;
  wire                                underflow_evt;
  wire                                low_res;
  wire                                low_res_lsb;
  wire                                fast_fifo_read_mode;
  wire [adcfifo_pkg::THRESH_W-1:0]    stream_segment_threshold;
  wire                                clear_fifo_errors;
  wire                                no_underflow_errors;
  wire                                arm;
  wire                                capture_done;
  adcfifo_pkg::cap_state_t            cap_state;
  adcfifo_pkg::cap_state_t            fifo_first_error_state;
  wire [adcfifo_pkg::ERR_W-1:0]       fifo_error_stat;
  wire [adcfifo_pkg::ERR_W-1:0]       fifo_first_error_stat;
  wire [7:0]                          underflow_count;
  wire [31:0]                         fifo_read_count;
  wire [31:0]                         fifo_read_count_error_freeze;

  reg_adcfifo #(.BYTECNT_W(BYTECNT_W)) reg_adcfifo_i (  // host register block
    .clk_usb, .reset, .reg_address, .reg_bytecnt, .reg_datai, .reg_datao,
    .reg_read, .reg_write, .fifo_dout, .fifo_empty, .cap_state, .capture_done,
    .fifo_error_stat, .fifo_first_error_stat, .fifo_first_error_state,
    .underflow_count, .fifo_read_count, .fifo_read_count_error_freeze,
    .fifo_rd_en, .low_res, .low_res_lsb, .fast_fifo_read_mode,
    .stream_segment_threshold, .clear_fifo_errors, .no_underflow_errors, .arm
  );

  adc_capture_ctrl adc_capture_ctrl_i (      // sequencer and byte packer
    .clk_usb, .reset, .arm, .trigger, .adc_data, .adc_valid, .low_res,
    .low_res_lsb, .stream_segment_threshold, .fifo_wr_en, .fifo_din,
    .fifo_flush, .cap_state, .capture_done
  );

  adc_sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) adc_sample_fifo_i (
    .clk_usb, .reset, .fifo_flush, .fifo_wr_en, .fifo_din, .fifo_rd_en,
    .fifo_dout, .fifo_empty, .overflow_evt, .underflow_evt
  );

  fifo_error_tracker fifo_error_tracker_i (  // flags and debug counters
    .clk_usb, .reset, .overflow_evt, .underflow_evt, .fifo_rd_en,
    .fast_fifo_read_mode, .no_underflow_errors, .clear_fifo_errors, .cap_state,
    .fifo_error_stat, .fifo_first_error_stat, .fifo_first_error_state,
    .underflow_count, .fifo_read_count, .fifo_read_count_error_freeze
  );

endmodule

`default_nettype wire

// File: testbench/tb_adc_fifo_top.sv
`default_nettype none

module tb_adc_fifo_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FIFO_DEPTH     = 64;
  localparam int BYTECNT_W      = 7;
  localparam int TEST_CYCLES    = 16 + 30 + 150 + 220 + 270 + 60;  // per test, rough
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                          clk_usb;
  logic                          reset;
  logic [7:0]                    reg_address;
  logic [BYTECNT_W-1:0]          reg_bytecnt;
  logic [7:0]                    reg_datai;
  wire  [7:0]                    reg_datao;
  logic                          reg_read;
  logic                          reg_write;
  logic [adcfifo_pkg::ADC_W-1:0] adc_data;
  logic                          adc_valid;
  logic                          trigger;

  logic [31:0] lfsr;                         // sample generator state
  logic [7:0]  exp_q[$];                     // bytes the model predicts
  logic [7:0]  act_q[$];                     // bytes read back from the dut
  int          pops_total;                   // every read of ADCREAD_ADDR
  int          cycle_cnt;
  int          byte_idx;
  string       test_name;

  adc_fifo_top #(.FIFO_DEPTH(FIFO_DEPTH), .BYTECNT_W(BYTECNT_W)) adc_fifo_top_i (
    .clk_usb, .reset, .reg_address, .reg_bytecnt, .reg_datai, .reg_datao,
    .reg_read, .reg_write, .adc_data, .adc_valid, .trigger
  );

  initial begin
    clk_usb = 1'b0;
    forever #10 clk_usb = ~clk_usb;          // 20 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      abort_run($sformatf("error %s: %s expected %02h actual %02h", test_name, what, exp, act));
  endtask

  task automatic check_state(input string what, input adcfifo_pkg::cap_state_t exp,
                             input adcfifo_pkg::cap_state_t act);
    if (act !== exp)
      abort_run($sformatf("error %s: %s expected %s actual %s",
                          test_name, what, exp.name(), act.name()));
  endtask

  task automatic check_count(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      abort_run($sformatf("error %s: %s expected %0d actual %0d", test_name, what, exp, act));
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_usb);
  endtask

  task automatic reg_wr(input adcfifo_pkg::reg_addr_t addr, input int bc, input logic [7:0] data);
    @(posedge clk_usb);
    #2;
    reg_address = addr;
    reg_bytecnt = BYTECNT_W'(bc);
    reg_datai   = data;
    reg_write   = 1'b1;
    @(posedge clk_usb);                      // write lands on this edge
    #2 reg_write = 1'b0;
  endtask

  task automatic reg_rd(input adcfifo_pkg::reg_addr_t addr, input int bc, output logic [7:0] d);
    @(posedge clk_usb);
    #2;
    reg_address = addr;
    reg_bytecnt = BYTECNT_W'(bc);
    reg_read    = 1'b1;
    #8 d = reg_datao;                        // mid cycle, comb read data settled
    @(posedge clk_usb);
    #2 reg_read = 1'b0;                      // next call leaves one idle cycle
  endtask

  task automatic read_word(input adcfifo_pkg::reg_addr_t addr, output logic [31:0] w);
    logic [7:0] b;
    w = '0;
    for (int i = 0; i < 4; i++) begin
      reg_rd(addr, i, b);
      w[i*8 +: 8] = b;                       // byte i at reg_bytecnt i
    end
  endtask

  task automatic read_state(input adcfifo_pkg::reg_addr_t addr,
                            output adcfifo_pkg::cap_state_t st);
    logic [7:0] b;
    reg_rd(addr, 0, b);
    st = adcfifo_pkg::cap_state_t'(b[2:0]);
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_sample(output logic [adcfifo_pkg::ADC_W-1:0] s);
    for (int i = 0; i < adcfifo_pkg::ADC_W; i++) begin
      lfsr = lfsr_next(lfsr);                // one step per bit
      s    = {s[adcfifo_pkg::ADC_W-2:0], lfsr[0]};
    end
  endtask

  // first byte in [15:8], second byte in [7:0] for full res only
  function automatic logic [15:0] pack_sample(input logic [9:0] s, input logic lr,
                                              input logic lsb);
    if (lr)
      return {(lsb ? s[7:0] : s[9:2]), 8'h00};
    return {6'b0, s[9:8], s[7:0]};           // msbs then lsbs
  endfunction

  task automatic expect_sample(input logic [9:0] s, input logic lr, input logic lsb);
    logic [15:0] p;
    p = pack_sample(s, lr, lsb);
    exp_q.push_back(p[15:8]);
    if (!lr) exp_q.push_back(p[7:0]);
  endtask

  task automatic adc_read(input bit compare);
    logic [7:0] b;
    reg_rd(adcfifo_pkg::ADCREAD_ADDR, 0, b);
    pops_total++;
    if (compare) act_q.push_back(b);         // underflow reads carry no data
  endtask

  task automatic run_capture(input int n, input logic lr, input logic lsb);
    logic [16:0]                    th;
    logic [9:0]                     s;
    logic [7:0]                     b;
    adcfifo_pkg::cap_state_t        st;
    th = 17'(n);
    reg_wr(adcfifo_pkg::STREAM_SEGMENT_THRESHOLD, 0, th[7:0]);
    reg_wr(adcfifo_pkg::STREAM_SEGMENT_THRESHOLD, 1, th[15:8]);
    reg_wr(adcfifo_pkg::STREAM_SEGMENT_THRESHOLD, 2, {7'b0, th[16]});
    reg_wr(adcfifo_pkg::ADC_LOW_RES, 0, {6'b0, lsb, lr});
    reg_wr(adcfifo_pkg::CAPTURE_ARM, 0, 8'h01);
    read_state(adcfifo_pkg::FIFO_STATE, st);
    check_state("state after arm", adcfifo_pkg::CAP_ARMED, st);
    @(posedge clk_usb);
    #2 trigger = 1'b1;
    @(posedge clk_usb);                      // capturing from here
    #2 trigger = 1'b0;
    for (int i = 0; i < n; i++) begin
      draw_sample(s);
      expect_sample(s, lr, lsb);
      adc_data  = s;
      adc_valid = 1'b1;
      @(posedge clk_usb);
      #2 adc_valid = 1'b0;                   // idle cycle for the second byte
      @(posedge clk_usb);
      #2;
    end
    b = 8'h00;
    while (!b[0]) reg_rd(adcfifo_pkg::CAPTURE_DONE, 0, b);  // timeout guards this
    read_state(adcfifo_pkg::FIFO_STATE, st);
    check_state("state after capture", adcfifo_pkg::CAP_DONE, st);
  endtask

  always @(posedge clk_usb) begin : compare_bytes
    logic [7:0] e;
    logic [7:0] a;
    while (act_q.size() > 0) begin
      if (exp_q.size() == 0) begin
        abort_run("an ADC read returned a byte that no sample produced");
      end else begin
        e = exp_q.pop_front();
        a = act_q.pop_front();
        check_byte($sformatf("adc byte %0d", byte_idx), e, a);
        byte_idx++;
      end
    end
  end

  always @(posedge clk_usb) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES)
      abort_run($sformatf("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  initial begin
    logic [7:0]              d;
    logic [31:0]             w;
    logic [31:0]             base_reads;
    adcfifo_pkg::cap_state_t st;
    reset       = 1'b1;
    reg_address = 8'h00;
    reg_bytecnt = '0;
    reg_datai   = 8'h00;
    reg_read    = 1'b0;
    reg_write   = 1'b0;
    adc_data    = '0;
    adc_valid   = 1'b0;
    trigger     = 1'b0;
    lfsr        = 32'h8f4b;
    pops_total  = 0;
    cycle_cnt   = 0;
    byte_idx    = 0;
    repeat (2) @(posedge clk_usb);
    #2 reset = 1'b0;

    test_name = "reset values";
    for (int i = 0; i < 3; i++) begin
      reg_rd(adcfifo_pkg::STREAM_SEGMENT_THRESHOLD, i, d);
      check_byte("threshold byte", (i == 2) ? 8'h01 : 8'h00, d);  // 65536
    end
    reg_rd(adcfifo_pkg::ADC_LOW_RES, 0, d);
    check_byte("low res", 8'h00, d);
    read_state(adcfifo_pkg::FIFO_STATE, st);
    check_state("state", adcfifo_pkg::CAP_IDLE, st);
    reg_rd(adcfifo_pkg::CAPTURE_DONE, 0, d);
    check_byte("capture done", 8'h00, d);
    reg_rd(adcfifo_pkg::FIFO_STAT, 0, d);
    check_byte("fifo stat", 8'h80, d);       // empty, no flags

    test_name = "register access";
    reg_wr(adcfifo_pkg::STREAM_SEGMENT_THRESHOLD, 0, 8'h34);
    reg_wr(adcfifo_pkg::STREAM_SEGMENT_THRESHOLD, 1, 8'h12);
    reg_wr(adcfifo_pkg::STREAM_SEGMENT_THRESHOLD, 2, 8'h01);
    reg_rd(adcfifo_pkg::STREAM_SEGMENT_THRESHOLD, 0, d);
    check_byte("threshold byte 0", 8'h34, d);
    reg_rd(adcfifo_pkg::STREAM_SEGMENT_THRESHOLD, 1, d);
    check_byte("threshold byte 1", 8'h12, d);
    reg_rd(adcfifo_pkg::STREAM_SEGMENT_THRESHOLD, 2, d);
    check_byte("threshold byte 2", 8'h01, d);
    reg_wr(adcfifo_pkg::ADC_LOW_RES, 0, 8'h03);
    reg_rd(adcfifo_pkg::ADC_LOW_RES, 0, d);
    check_byte("low res and lsb", 8'h03, d);
    reg_wr(adcfifo_pkg::ADC_LOW_RES, 0, 8'h02);
    reg_rd(adcfifo_pkg::ADC_LOW_RES, 0, d);
    check_byte("lsb only", 8'h02, d);
    reg_wr(adcfifo_pkg::FIFO_NO_UNDERFLOW_ERROR, 0, 8'h01);
    reg_rd(adcfifo_pkg::FIFO_NO_UNDERFLOW_ERROR, 0, d);
    check_byte("no underflow set", 8'h01, d);
    reg_wr(adcfifo_pkg::FIFO_NO_UNDERFLOW_ERROR, 0, 8'h00);
    reg_rd(adcfifo_pkg::FIFO_NO_UNDERFLOW_ERROR, 0, d);
    check_byte("no underflow clear", 8'h00, d);

    test_name = "full res slow read";
    run_capture(20, 1'b0, 1'b0);             // 40 bytes
    repeat (40) adc_read(1'b1);
    reg_rd(adcfifo_pkg::FIFO_STAT, 0, d);
    check_byte("fifo stat", 8'h80, d);

    test_name = "low res fast read";
    run_capture(20, 1'b1, 1'b0);             // bits 9..2
    reg_wr(adcfifo_pkg::FAST_FIFO_READ_MODE, 0, 8'h01);
    repeat (20) adc_read(1'b1);
    run_capture(20, 1'b1, 1'b1);             // bits 7..0, arm drops fast mode
    reg_wr(adcfifo_pkg::FAST_FIFO_READ_MODE, 0, 8'h01);
    repeat (20) adc_read(1'b1);
    read_word(adcfifo_pkg::DEBUG_FIFO_READS, w);
    check_count("fifo reads", 32'(pops_total), w);

    test_name = "overflow";
    read_word(adcfifo_pkg::DEBUG_FIFO_READS, base_reads);
    run_capture(40, 1'b0, 1'b0);             // 80 bytes into 64 entries
    reg_rd(adcfifo_pkg::FIFO_STAT, 0, d);
    check_byte("fifo stat", 8'h01, d);
    reg_rd(adcfifo_pkg::FIFO_FIRST_ERROR, 0, d);
    check_byte("first error", 8'h01, d);
    read_state(adcfifo_pkg::FIFO_FIRST_ERROR_STATE, st);
    check_state("first error state", adcfifo_pkg::CAP_CAPTURING, st);
    read_word(adcfifo_pkg::DEBUG_FIFO_READS_FREEZE, w);
    check_count("frozen reads", base_reads, w);
    while (exp_q.size() > FIFO_DEPTH)
      exp_q.delete(exp_q.size() - 1);        // tail bytes were dropped
    repeat (FIFO_DEPTH) adc_read(1'b1);      // oldest bytes survive
    reg_wr(adcfifo_pkg::FIFO_STAT, 0, 8'h01);
    reg_wr(adcfifo_pkg::FIFO_STAT, 0, 8'h00);
    reg_rd(adcfifo_pkg::FIFO_STAT, 0, d);
    check_byte("fifo stat after clear", 8'h80, d);
    reg_rd(adcfifo_pkg::FIFO_FIRST_ERROR, 0, d);
    check_byte("first error after clear", 8'h00, d);

    test_name = "underflow";
    reg_wr(adcfifo_pkg::FIFO_NO_UNDERFLOW_ERROR, 0, 8'h01);
    repeat (3) adc_read(1'b0);
    idle(3);                                 // event then counter update
    reg_rd(adcfifo_pkg::FIFO_STAT, 0, d);
    check_byte("fifo stat masked", 8'h80, d);
    reg_rd(adcfifo_pkg::FIFO_UNDERFLOW_COUNT, 0, d);
    check_byte("underflow count", 8'h03, d);
    reg_wr(adcfifo_pkg::FIFO_NO_UNDERFLOW_ERROR, 0, 8'h00);
    repeat (2) adc_read(1'b0);
    idle(3);
    reg_rd(adcfifo_pkg::FIFO_STAT, 0, d);
    check_byte("fifo stat slow", 8'h82, d);
    reg_rd(adcfifo_pkg::FIFO_FIRST_ERROR, 0, d);
    check_byte("first error", 8'h02, d);
    reg_wr(adcfifo_pkg::FAST_FIFO_READ_MODE, 0, 8'h01);
    repeat (2) adc_read(1'b0);
    idle(3);
    reg_rd(adcfifo_pkg::FIFO_STAT, 0, d);
    check_byte("fifo stat fast", 8'h86, d);
    reg_rd(adcfifo_pkg::FIFO_UNDERFLOW_COUNT, 0, d);
    check_byte("underflow count", 8'h07, d);
    read_word(adcfifo_pkg::DEBUG_FIFO_READS, w);
    check_count("fifo reads", 32'(pops_total), w);

    idle(2);                                 // let the comparer drain
    if (exp_q.size() != 0 || act_q.size() != 0) begin
      abort_run("expected bytes were left over at the end of the run");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: adc_fifo_top.f
rtl/adcfifo_pkg.sv
rtl/reg_adcfifo.sv
rtl/adc_capture_ctrl.sv
rtl/adc_sample_fifo.sv
rtl/fifo_error_tracker.sv
rtl/adc_fifo_top.sv
testbench/tb_adc_fifo_top.sv

// File: Makefile
# Verilator build and run for the ADC capture buffer
VERILATOR ?= verilator
TOP       ?= tb_adc_fifo_top
FILELIST  ?= adc_fifo_top.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
